//--- design/saturn_bus_arbiter.sv
// Program ring arbiter
// Round-robin between the fetch and debug peers; the winner keeps the
// ring until the last entry of its program has been taken
`timescale 1ns/1ps
`default_nettype none

module saturn_bus_arbiter (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_fetch_req,
    input  saturn_bus_pkg::prog_entry_t i_fetch_entry,
    input  logic                        i_fetch_last,
    input  logic                        i_dbg_req,
    input  saturn_bus_pkg::prog_entry_t i_dbg_entry,
    input  logic                        i_dbg_last,
    input  logic                        i_full,
    output logic                        o_fetch_gnt,
    output logic                        o_dbg_gnt,
    output logic                        o_wr_en,
    output saturn_bus_pkg::prog_entry_t o_wr_entry
);

    import saturn_core_pkg::*;

    requester_t owner;                  // Locked owner
    requester_t pref;                   // Favoured when both ask
    requester_t sel;
    logic       locked;
    logic       sel_last;

    always_comb begin
        if (locked)                      sel = owner;
        else if (i_fetch_req && i_dbg_req) sel = pref;
        else if (i_dbg_req)              sel = REQ_DEBUG;
        else                             sel = REQ_FETCH;
    end

    assign o_fetch_gnt = (sel == REQ_FETCH) && i_fetch_req;
    assign o_dbg_gnt   = (sel == REQ_DEBUG) && i_dbg_req;
    assign o_wr_en     = (o_fetch_gnt || o_dbg_gnt) && !i_full;    // Full ring stalls
    assign o_wr_entry  = (sel == REQ_FETCH) ? i_fetch_entry : i_dbg_entry;
    assign sel_last    = (sel == REQ_FETCH) ? i_fetch_last : i_dbg_last;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            locked <= 1'b0;
            owner  <= REQ_FETCH;
            pref   <= REQ_FETCH;
        end else if (o_wr_en) begin
            locked <= !sel_last;        // Release after the last entry
            owner  <= sel;
            if (sel_last) begin
                pref <= (sel == REQ_FETCH) ? REQ_DEBUG : REQ_FETCH;
            end
        end
    end

    a_one_grant: assert property (
        @(posedge i_clk) disable iff (i_reset) !(o_fetch_gnt && o_dbg_gnt)
    );

endmodule

`default_nettype wire

//--- design/saturn_bus_controller.sv
// Nibble bus controller
// Drains the program ring one entry per bus cycle in the send slot,
// performs reads when nothing is queued and the fetch side wants
// nibbles, and tracks whether the bus is still busy
`timescale 1ns/1ps
`default_nettype none

module saturn_bus_controller (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_clk_en,
    input  saturn_bus_pkg::phases_t     i_phases,
    input  saturn_bus_pkg::prog_entry_t i_rd_entry,
    input  logic                        i_empty,
    output logic                        o_rd_en,
    input  logic                        i_no_read,
    output logic                        o_bus_clk_en,
    output logic                        o_bus_is_data,
    output saturn_bus_pkg::nibble_t     o_bus_nibble_out,
    input  saturn_bus_pkg::nibble_t     i_bus_nibble_in,
    output logic                        o_read_valid,
    output saturn_bus_pkg::nibble_t     o_read_nibble,
    output logic                        o_busy
);

    import saturn_bus_pkg::*;

    logic send_slot;
    logic read_start;
    logic read_cycle;                   // Current strobe is a read

    assign send_slot  = i_clk_en && i_phases[PH_SEND];
    assign o_rd_en    = send_slot && !i_empty;              // Pop head of ring
    assign read_start = send_slot && i_empty && !i_no_read; // Nothing queued, fetch wants data

    always_ff @(posedge i_clk) begin
        o_read_valid <= 1'b0;           // Single clock pulse
        if (i_reset) begin
            o_bus_clk_en <= 1'b0;
            read_cycle   <= 1'b0;
            o_busy       <= 1'b1;
        end else if (i_clk_en) begin
            if (o_rd_en) begin
                o_bus_clk_en <= 1'b1;
                read_cycle   <= 1'b0;
                o_busy       <= 1'b1;
            end else if (read_start) begin
                o_bus_clk_en <= 1'b1;
                read_cycle   <= 1'b1;
            end
            if (i_phases[PH_READ] && o_bus_clk_en) begin
                o_bus_clk_en <= 1'b0;   // Strobe ends in read slot
                read_cycle   <= 1'b0;
                o_read_valid <= read_cycle;
            end
            if (i_phases[PH_IDLE] && i_empty) begin
                o_busy <= 1'b0;         // Whole program sent
            end
        end
    end

    // Bus data path
    always_ff @(posedge i_clk) begin
        if (o_rd_en) begin
            o_bus_is_data    <= !i_rd_entry.is_cmd;
            o_bus_nibble_out <= i_rd_entry.nibble;
        end else if (read_start) begin
            o_bus_is_data <= 1'b1;
        end
        if (i_clk_en && i_phases[PH_READ] && read_cycle) begin
            o_read_nibble <= i_bus_nibble_in;   // Sample memory nibble
        end
    end

    // Strobe always drops before the idle-check slot
    a_no_strobe_idle: assert property (
        @(posedge i_clk) disable iff (i_reset) i_phases[PH_IDLE] |-> !o_bus_clk_en
    );

endmodule

`default_nettype wire

//--- design/saturn_bus_pkg.sv
// Nibble bus types
// Phase slots of the four-phase bus cycle and the 5-bit program entry
// that travels from the requesters through the ring to the bus
`default_nettype none

`include "saturn_defs.svh"

package saturn_bus_pkg;

    typedef logic [`SATURN_NIBBLE_W-1:0] nibble_t;

    typedef logic [3:0] phases_t;   // One-hot bus phase

    localparam int PH_SEND  = 0;    // Command or data goes out
    localparam int PH_READ  = 1;    // Read nibble sampled, strobe drops
    localparam int PH_IDLE  = 2;    // Idle check
    localparam int PH_SPARE = 3;    // Last slot of the bus cycle

    typedef struct packed {
        logic    is_cmd;            // High for a command nibble
        nibble_t nibble;
    } prog_entry_t;

endpackage

`default_nettype wire

//--- design/saturn_bus_top.sv
// Nibble bus subsystem
// Phase sequencer, fetch and debug requesters, ring arbiter, program
// ring and bus controller
`timescale 1ns/1ps
`default_nettype none

`include "saturn_defs.svh"

module saturn_bus_top (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_clk_en,
    input  logic                    i_fetch_start,
    input  saturn_core_pkg::addr_t  i_fetch_addr,
    input  logic [7:0]              i_fetch_count,
    input  logic                    i_dbg_start,
    input  logic [15:0]             i_dbg_value,
    input  saturn_bus_pkg::nibble_t i_bus_nibble_in,
    output logic                    o_bus_clk_en,
    output logic                    o_bus_is_data,
    output saturn_bus_pkg::nibble_t o_bus_nibble_out,
    output logic                    o_read_valid,
    output saturn_bus_pkg::nibble_t o_read_nibble,
    output logic                    o_fetch_done,
    output logic                    o_dbg_done,
    output logic                    o_busy
);

    import saturn_bus_pkg::*;

    phases_t     phases;
    prog_entry_t fetch_entry, dbg_entry, wr_entry, rd_entry;
    logic        fetch_req, fetch_last, fetch_gnt, no_read;
    logic        dbg_req, dbg_last, dbg_gnt;
    logic        wr_en, rd_en, empty, full;

    saturn_phase_gen phase_gen_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_clk_en(i_clk_en),
        .o_phases(phases), .o_cycle_ctr()
    );

    saturn_fetch_seq fetch_seq_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(i_fetch_start),
        .i_addr(i_fetch_addr), .i_count(i_fetch_count),
        .o_req(fetch_req), .o_entry(fetch_entry), .o_last(fetch_last),
        .i_gnt(fetch_gnt), .i_full(full), .o_no_read(no_read),
        .i_read_valid(o_read_valid), .o_done(o_fetch_done)
    );

    saturn_debug_port debug_port_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(i_dbg_start), .i_value(i_dbg_value),
        .o_req(dbg_req), .o_entry(dbg_entry), .o_last(dbg_last),
        .i_gnt(dbg_gnt), .i_full(full), .o_done(o_dbg_done)
    );

    saturn_bus_arbiter bus_arbiter_i (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_fetch_req(fetch_req), .i_fetch_entry(fetch_entry), .i_fetch_last(fetch_last),
        .i_dbg_req(dbg_req), .i_dbg_entry(dbg_entry), .i_dbg_last(dbg_last),
        .i_full(full), .o_fetch_gnt(fetch_gnt), .o_dbg_gnt(dbg_gnt),
        .o_wr_en(wr_en), .o_wr_entry(wr_entry)
    );

    saturn_prog_ring #(.AW(`SATURN_RING_AW)) prog_ring_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_wr_en(wr_en), .i_wr_entry(wr_entry),
        .i_rd_en(rd_en), .o_rd_entry(rd_entry), .o_empty(empty), .o_full(full)
    );

    saturn_bus_controller bus_controller_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_clk_en(i_clk_en), .i_phases(phases),
        .i_rd_entry(rd_entry), .i_empty(empty), .o_rd_en(rd_en), .i_no_read(no_read),
        .o_bus_clk_en(o_bus_clk_en), .o_bus_is_data(o_bus_is_data),
        .o_bus_nibble_out(o_bus_nibble_out), .i_bus_nibble_in(i_bus_nibble_in),
        .o_read_valid(o_read_valid), .o_read_nibble(o_read_nibble), .o_busy(o_busy)
    );

endmodule

`default_nettype wire

//--- design/saturn_core_pkg.sv
// Core side types
// Identity of the bus requesters and the Saturn address type
`default_nettype none

`include "saturn_defs.svh"

package saturn_core_pkg;

    // Peers that can own the program ring
    typedef enum logic {
        REQ_FETCH = 1'b0,
        REQ_DEBUG = 1'b1
    } requester_t;

    // 20-bit address made of five nibbles
    typedef logic [`SATURN_ADDR_NIBBLES*4-1:0] addr_t;

endpackage

`default_nettype wire

//--- design/saturn_debug_port.sv
// Debug write port
// Sends a WRITE command followed by the four nibbles of a 16-bit
// value, lowest first, and pulses done when the last one is taken
`timescale 1ns/1ps
`default_nettype none

`include "saturn_defs.svh"

module saturn_debug_port (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_start,
    input  logic [15:0]                 i_value,
    output logic                        o_req,
    output saturn_bus_pkg::prog_entry_t o_entry,
    output logic                        o_last,
    input  logic                        i_gnt,
    input  logic                        i_full,
    output logic                        o_done
);

    logic [15:0] value_q;
    logic [2:0]  idx;                   // 0 is the command entry
    logic        take;

    assign take           = o_req && i_gnt && !i_full;
    assign o_last         = (idx == 3'd4);
    assign o_entry.is_cmd = (idx == 3'd0);
    assign o_entry.nibble = (idx == 3'd0) ? `SATURN_CMD_WRITE : value_q[3:0];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_req  <= 1'b0;
            o_done <= 1'b0;
            idx    <= 3'd0;
        end else begin
            o_done <= take && o_last;   // One clock after last entry
            if (i_start && !o_req) begin
                o_req <= 1'b1;
                idx   <= 3'd0;
            end else if (take) begin
                idx <= idx + 3'd1;
                if (o_last) o_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start && !o_req) begin
            value_q <= i_value;
        end else if (take && idx != 3'd0) begin
            value_q <= value_q >> 4;    // Next nibble to the bottom
        end
    end

endmodule

`default_nettype wire

//--- design/saturn_fetch_seq.sv
// Instruction fetch sequencer
// Sends a LOAD_PC program with the five address nibbles, then asks the
// bus controller for a given number of nibble reads
`timescale 1ns/1ps
`default_nettype none

`include "saturn_defs.svh"

module saturn_fetch_seq (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_start,
    input  saturn_core_pkg::addr_t      i_addr,
    input  logic [7:0]                  i_count,
    output logic                        o_req,
    output saturn_bus_pkg::prog_entry_t o_entry,
    output logic                        o_last,
    input  logic                        i_gnt,
    input  logic                        i_full,
    output logic                        o_no_read,
    input  logic                        i_read_valid,
    output logic                        o_done
);

    import saturn_core_pkg::*;

    addr_t      addr_q;                 // Shifts down one nibble per data entry
    logic [7:0] count_q;
    logic [7:0] owed;                   // Reads still expected
    logic [2:0] idx;                    // 0 is the command entry
    logic       take;

    assign take           = o_req && i_gnt && !i_full;
    assign o_last         = (idx == 3'(`SATURN_ADDR_NIBBLES));
    assign o_entry.is_cmd = (idx == 3'd0);
    assign o_entry.nibble = (idx == 3'd0) ? `SATURN_CMD_LOAD_PC : addr_q[3:0];
    assign o_no_read      = (owed == 8'd0);

    always_ff @(posedge i_clk) begin
        o_done <= 1'b0;
        if (i_reset) begin
            o_req <= 1'b0;
            idx   <= 3'd0;
            owed  <= 8'd0;
        end else begin
            if (i_start && !o_req && o_no_read) begin
                o_req <= 1'b1;
                idx   <= 3'd0;
            end
            if (take) begin
                idx <= idx + 3'd1;
                if (o_last) begin
                    o_req  <= 1'b0;
                    owed   <= count_q;
                    o_done <= (count_q == 8'd0);    // No reads wanted
                end
            end
            if (!o_no_read && i_read_valid) begin
                owed <= owed - 8'd1;
                if (owed == 8'd1) o_done <= 1'b1;   // Last read seen
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start && !o_req && o_no_read) begin
            addr_q  <= i_addr;
            count_q <= i_count;
        end else if (take && idx != 3'd0) begin
            addr_q <= addr_q >> 4;      // Lowest nibble first
        end
    end

endmodule

`default_nettype wire

//--- design/saturn_phase_gen.sv
// Four-phase bus sequencer
// Rotates a one-hot phase on every enabled clock and counts the
// bus cycles that have completed
`timescale 1ns/1ps
`default_nettype none

module saturn_phase_gen (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_clk_en,
    output saturn_bus_pkg::phases_t o_phases,
    output logic [31:0]             o_cycle_ctr
);

    import saturn_bus_pkg::*;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_phases    <= phases_t'(1 << PH_SEND);     // Start in send slot
            o_cycle_ctr <= 32'd0;
        end else if (i_clk_en) begin
            o_phases <= {o_phases[2:0], o_phases[3]};   // Rotate left
            if (o_phases[PH_SPARE]) begin
                o_cycle_ctr <= o_cycle_ctr + 32'd1;     // Cycle wraps to phase 0
            end
        end
    end

    // Exactly one phase active at any time
    a_phase_onehot: assert property (
        @(posedge i_clk) disable iff (i_reset) $onehot(o_phases)
    );

endmodule

`default_nettype wire

//--- design/saturn_prog_ring.sv
// Bus program ring
// Circular list of program entries shared by the requesters; the head
// entry is shown before it is popped
`timescale 1ns/1ps
`default_nettype none

`include "saturn_defs.svh"

module saturn_prog_ring #(
    parameter int AW = `SATURN_RING_AW
) (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_wr_en,
    input  saturn_bus_pkg::prog_entry_t i_wr_entry,
    input  logic                        i_rd_en,
    output saturn_bus_pkg::prog_entry_t o_rd_entry,
    output logic                        o_empty,
    output logic                        o_full
);

    import saturn_bus_pkg::*;

    prog_entry_t mem [0:(1<<AW)-1];
    logic [AW:0] wr_ptr;                // Top bit is the wrap flag
    logic [AW:0] rd_ptr;

    assign o_empty    = (wr_ptr == rd_ptr);
    assign o_full     = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);
    assign o_rd_entry = mem[rd_ptr[AW-1:0]];  // Head of list

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[wr_ptr[AW-1:0]] <= i_wr_entry;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (i_rd_en) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Arbiter must respect full, controller must respect empty
    a_no_write_full: assert property (
        @(posedge i_clk) disable iff (i_reset) i_wr_en |-> !o_full
    );
    a_no_read_empty: assert property (
        @(posedge i_clk) disable iff (i_reset) i_rd_en |-> !o_empty
    );

endmodule

`default_nettype wire

//--- include/saturn_defs.svh
// Saturn nibble bus constants
// Ring depth, nibble width, address length and the command nibbles
// used when building bus programs
`ifndef SATURN_DEFS_SVH
`define SATURN_DEFS_SVH

// Program ring address width for 32 entries
`define SATURN_RING_AW 5

// Width of one bus nibble
`define SATURN_NIBBLE_W 4

// Nibbles in a 20-bit Saturn address
`define SATURN_ADDR_NIBBLES 5

// Bus command nibbles
`define SATURN_CMD_LOAD_PC 4'h4
`define SATURN_CMD_WRITE   4'h5

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the Saturn nibble bus testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module saturn_bus_tb \
    -Mdir obj_dir -o saturn_bus_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/saturn_bus_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Simulation did not report success"
exit 1

//--- sources.f
+incdir+include
design/saturn_bus_pkg.sv
design/saturn_core_pkg.sv
design/saturn_phase_gen.sv
design/saturn_prog_ring.sv
design/saturn_bus_arbiter.sv
design/saturn_bus_controller.sv
design/saturn_fetch_seq.sv
design/saturn_debug_port.sv
design/saturn_bus_top.sv
tests/saturn_bus_tb.sv

//--- tests/saturn_bus_tb.sv
// Testbench for the Saturn nibble bus subsystem
// Applies a table of fetch, debug and contention operations, models the
// memory side of the nibble bus and compares every bus cycle
`timescale 1ns/1ps
`default_nettype none

`include "saturn_defs.svh"

module saturn_bus_tb;

    localparam logic [1:0] K_FETCH = 2'd0;
    localparam logic [1:0] K_DEBUG = 2'd1;
    localparam logic [1:0] K_BOTH  = 2'd2;      // Both starts in one clock
    localparam int NUM_ROWS = 8;

    typedef struct packed {
        logic [1:0]  kind;
        logic [19:0] addr;                      // Fetch address
        logic [7:0]  count;                     // Reads after the fetch
        logic [31:0] rdata;                     // Read nibbles with the first in bits 3:0
        logic [15:0] value;                     // Debug write value
        logic        gaps;                      // Random clock enable gaps
    } row_t;

    logic        i_clk = 1'b0;
    logic        i_reset, i_clk_en, i_fetch_start, i_dbg_start;
    logic [19:0] i_fetch_addr;
    logic [7:0]  i_fetch_count;
    logic [15:0] i_dbg_value;
    logic [3:0]  i_bus_nibble_in;
    logic        o_bus_clk_en, o_bus_is_data, o_read_valid, o_fetch_done, o_dbg_done, o_busy;
    logic [3:0]  o_bus_nibble_out, o_read_nibble;

    row_t        table_rows [NUM_ROWS];
    logic        cyc_data[$], cyc_read[$], exp_data[$], exp_read[$];    // Seen and expected cycles
    logic [3:0]  cyc_nib[$], exp_nib[$];
    logic [31:0] cur_rdata;
    logic        gaps_on = 1'b0;
    logic        strobe_q = 1'b0;
    logic        debug_first = 1'b0;            // Peer favoured on the next contention
    int          rd_idx, fetch_dones, dbg_dones, reads_at_done, n;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;

    saturn_bus_top saturn_bus_top_i (.*);

    always #2 i_clk = ~i_clk;                   // 4 ns period

    // Clock enable pattern and memory side of the bus
    always @(posedge i_clk) begin
        i_clk_en        <= gaps_on ? ($urandom % 3 != 0) : 1'b1;
        i_bus_nibble_in <= cur_rdata[4*rd_idx +: 4];    // Next nibble the memory returns
    end

    // Bus monitor sampled away from the active edge
    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (o_bus_clk_en && !strobe_q) begin
                cyc_data.push_back(o_bus_is_data);
                cyc_nib.push_back(o_bus_nibble_out);
                cyc_read.push_back(1'b0);       // Marked later if data comes back
            end
            if (o_read_valid) begin
                checks++;
                if (cyc_read.size() == 0) begin
                    report_error("read pulse without any bus cycle");
                end else begin
                    cyc_read[cyc_read.size()-1] = 1'b1;
                end
                if (o_read_nibble != cur_rdata[4*rd_idx +: 4]) begin
                    report_error($sformatf("read %0d gave %h, expected %h",
                                           rd_idx, o_read_nibble, cur_rdata[4*rd_idx +: 4]));
                end
                rd_idx++;
            end
            if (o_fetch_done) begin
                fetch_dones++;
                reads_at_done = rd_idx;
            end
            if (o_dbg_done) dbg_dones++;
        end
        strobe_q = o_bus_clk_en;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic flag_timeout(input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic push_cycle(input logic is_data, input logic [3:0] nib, input logic is_read);
        exp_data.push_back(is_data);
        exp_nib.push_back(nib);
        exp_read.push_back(is_read);
    endtask

    // Command followed by address or value nibbles lowest first
    task automatic add_fetch_prog(input logic [19:0] addr);
        push_cycle(1'b0, `SATURN_CMD_LOAD_PC, 1'b0);
        for (int k = 0; k < `SATURN_ADDR_NIBBLES; k++) push_cycle(1'b1, addr[4*k +: 4], 1'b0);
    endtask

    task automatic add_debug_prog(input logic [15:0] value);
        push_cycle(1'b0, `SATURN_CMD_WRITE, 1'b0);
        for (int k = 0; k < 4; k++) push_cycle(1'b1, value[4*k +: 4], 1'b0);
    endtask

    task automatic build_expected(input row_t row);
        exp_data.delete();
        exp_nib.delete();
        exp_read.delete();
        if (row.kind == K_FETCH) begin
            add_fetch_prog(row.addr);
            debug_first = 1'b1;                 // Other peer favoured after a program
        end else if (row.kind == K_DEBUG) begin
            add_debug_prog(row.value);
            debug_first = 1'b0;
        end else if (debug_first) begin
            add_debug_prog(row.value);          // Favoured peer ends up favoured again
            add_fetch_prog(row.addr);
        end else begin
            add_fetch_prog(row.addr);
            add_debug_prog(row.value);
        end
        if (row.kind != K_DEBUG) begin
            for (int k = 0; k < int'(row.count); k++) push_cycle(1'b1, 4'h0, 1'b1);
        end
    endtask

    function automatic bit row_finished(input bit want_f, input bit want_d);
        return cyc_nib.size() >= exp_nib.size() && fetch_dones == int'(want_f)
            && dbg_dones == int'(want_d) && !o_busy && !o_read_valid;
    endfunction

    task automatic run_row(input int r, input row_t row);
        bit want_f;
        bit want_d;
        int i;
        want_f = (row.kind != K_DEBUG);
        want_d = (row.kind != K_FETCH);
        build_expected(row);
        @(negedge i_clk);                       // Bus is idle here
        cyc_data.delete();
        cyc_nib.delete();
        cyc_read.delete();
        rd_idx        = 0;
        fetch_dones   = 0;
        dbg_dones     = 0;
        reads_at_done = 0;
        cur_rdata     = row.rdata;
        gaps_on       = row.gaps;
        @(posedge i_clk);
        i_fetch_addr  <= row.addr;
        i_fetch_count <= row.count;
        i_dbg_value   <= row.value;
        i_fetch_start <= want_f;
        i_dbg_start   <= want_d;
        @(posedge i_clk);
        i_fetch_start <= 1'b0;
        i_dbg_start   <= 1'b0;
        @(negedge i_clk);
        n = 0;
        while (!row_finished(want_f, want_d) && n < 2000) begin
            @(negedge i_clk);
            n++;
        end
        if (!row_finished(want_f, want_d)) begin
            flag_timeout($sformatf("table row %0d", r));
        end else begin
            repeat (16) @(negedge i_clk);       // Quiet window shows extra cycles
            checks++;
            if (cyc_nib.size() != exp_nib.size()) begin
                report_error($sformatf("row %0d: %0d bus cycles, expected %0d",
                                       r, cyc_nib.size(), exp_nib.size()));
            end
            for (i = 0; i < exp_nib.size() && i < cyc_nib.size(); i++) begin
                checks++;
                if (cyc_data[i] != exp_data[i] || cyc_read[i] != exp_read[i]
                    || (!exp_read[i] && cyc_nib[i] != exp_nib[i])) begin
                    report_error($sformatf("row %0d cycle %0d: got %0b %0b %h, exp %0b %0b %h",
                                           r, i, cyc_data[i], cyc_read[i], cyc_nib[i],
                                           exp_data[i], exp_read[i], exp_nib[i]));
                end
            end
            checks++;
            if (want_f && reads_at_done != int'(row.count)) begin
                report_error($sformatf("row %0d: fetch done after %0d reads, expected %0d",
                                       r, reads_at_done, row.count));
            end
        end
    endtask

    initial begin
        void'($urandom(17441));
        i_reset         = 1'b1;
        i_clk_en        = 1'b1;
        i_fetch_start   = 1'b0;
        i_dbg_start     = 1'b0;
        i_fetch_addr    = '0;
        i_fetch_count   = '0;
        i_dbg_value     = '0;
        i_bus_nibble_in = '0;
        cur_rdata       = '0;
        rd_idx          = 0;
        table_rows[0] = '{K_FETCH, 20'h1A2B3, 8'd3, 32'h0000_0C5E, 16'h0000, 1'b0};
        table_rows[1] = '{K_DEBUG, 20'h00000, 8'd0, 32'h0000_0000, 16'hBEEF, 1'b0};
        table_rows[2] = '{K_BOTH,  20'h00F42, 8'd2, 32'h0000_0097, 16'h1234, 1'b0};
        table_rows[3] = '{K_FETCH, 20'hFFFFF, 8'd1, 32'h0000_000A, 16'h0000, 1'b0};
        table_rows[4] = '{K_BOTH,  20'h54321, 8'd4, 32'h0000_6DB1, 16'hA5C3, 1'b1};
        table_rows[5] = '{K_DEBUG, 20'h00000, 8'd0, 32'h0000_0000, 16'h0F0F, 1'b1};
        table_rows[6] = '{K_FETCH, 20'h80001, 8'd5, 32'h0003_8E27, 16'h0000, 1'b1};
        table_rows[7] = '{K_BOTH,  20'h2468A, 8'd3, 32'h0000_0F1E, 16'h7E81, 1'b1};

        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        checks++;
        if (o_bus_clk_en || o_read_valid || o_fetch_done || o_dbg_done || !o_busy) begin
            report_error("outputs not in their reset state");
        end
        n = 0;
        while (o_busy && n < 10) begin
            @(negedge i_clk);
            n++;
        end
        if (o_busy) begin
            flag_timeout("busy to clear after reset");
        end else begin
            checks++;
            if (n != 3) report_error($sformatf("busy cleared after %0d clocks, expected 3", n));
        end

        for (int r = 0; r < NUM_ROWS && timeouts == 0; r++) begin
            run_row(r, table_rows[r]);
        end

        checks++;
        if (o_busy) report_error("busy still high after all operations");
        $display("Checks run: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
